/* common/dma_pkg.sv */
package dma_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;
   localparam int LEN_W  = 12;                  // 2048 bytes max for general DMA

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] byte_t;
   typedef logic [LEN_W-1:0]  xfer_len_t;

   // I/O register map
   localparam addr_t REG_OAM_DMA     = 16'hFF46;
   localparam addr_t REG_GDMA_SRC_HI = 16'hFF51;
   localparam addr_t REG_GDMA_SRC_LO = 16'hFF52;
   localparam addr_t REG_GDMA_DST_HI = 16'hFF53;
   localparam addr_t REG_GDMA_DST_LO = 16'hFF54;
   localparam addr_t REG_GDMA_CTRL   = 16'hFF55;

   // sprite attribute area FE00-FE9F
   localparam byte_t OAM_PAGE = 8'hFE;
   localparam int    OAM_LEN  = 160;

   // general DMA moves whole 16 byte blocks on 16 byte boundaries
   localparam int    GDMA_BLOCK = 16;
   localparam byte_t ALIGN_MASK = byte_t'(~(GDMA_BLOCK - 1));
   localparam addr_t VRAM_BASE  = 16'h8000;

   typedef enum logic {
      OAM_IDLE,
      OAM_COPY
   } oam_state_e;

   typedef enum logic {
      GDMA_IDLE,
      GDMA_COPY
   } gdma_state_e;

endpackage

/* common/dma_cfg_if.sv */
`timescale 1ns/10ps

interface dma_cfg_if;

   logic                 oam_start;            // one cycle strobe
   dma_pkg::byte_t       oam_src_page;
   logic                 gdma_start;           // one cycle strobe, bit 7 of FF55 was clear
   dma_pkg::addr_t       gdma_src;             // block aligned
   dma_pkg::addr_t       gdma_dst;             // inside VRAM, block aligned
   dma_pkg::xfer_len_t   gdma_len;             // in bytes

   modport decode (
      output oam_start,
      output oam_src_page,
      output gdma_start,
      output gdma_src,
      output gdma_dst,
      output gdma_len
   );

   modport oam (
      input oam_start,
      input oam_src_page
   );

   modport gdma (
      input gdma_start,
      input gdma_src,
      input gdma_dst,
      input gdma_len
   );

endinterface

/* common/dma_xfer_if.sv */
`timescale 1ns/10ps

interface dma_xfer_if;

   logic             active;                   // engine wants the port
   dma_pkg::addr_t   src_addr;
   dma_pkg::addr_t   dst_addr;
   logic             grant;                    // one byte moves when active and grant

   modport engine (
      output active,
      output src_addr,
      output dst_addr,
      input  grant
   );

   modport arbiter (
      input  active,
      input  src_addr,
      input  dst_addr,
      output grant
   );

endinterface

/* design/dma_reg_decode.sv */
`timescale 1ns/10ps

module dma_reg_decode (
   input  logic             I_CLK,
   input  logic             I_SYNC_RESET,
   input  dma_pkg::addr_t   ioreg_addr,
   input  dma_pkg::byte_t   ioreg_data,
   input  logic             ioreg_we,
   dma_cfg_if.decode        cfg
);

   dma_pkg::byte_t   oam_page_q;
   dma_pkg::byte_t   src_hi_q;
   dma_pkg::byte_t   src_lo_q;
   dma_pkg::byte_t   dst_hi_q;
   dma_pkg::byte_t   dst_lo_q;
   logic [6:0]       blocks_q;                 // length minus one, in blocks
   logic [7:0]       len_blocks;
   logic             oam_start_q;
   logic             gdma_start_q;

   // register file, written straight from the bus
   always_ff @(posedge I_CLK) begin
      if (ioreg_we) begin
         case (ioreg_addr)
            dma_pkg::REG_OAM_DMA:     oam_page_q <= ioreg_data;
            dma_pkg::REG_GDMA_SRC_HI: src_hi_q   <= ioreg_data;
            dma_pkg::REG_GDMA_SRC_LO: src_lo_q   <= ioreg_data;
            dma_pkg::REG_GDMA_DST_HI: dst_hi_q   <= ioreg_data;
            dma_pkg::REG_GDMA_DST_LO: dst_lo_q   <= ioreg_data;
            dma_pkg::REG_GDMA_CTRL:   blocks_q   <= ioreg_data[6:0];
            default: ;
         endcase
      end
   end

   // start strobes, high for the cycle after the write
   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         oam_start_q  <= 1'b0;
         gdma_start_q <= 1'b0;
      end else begin
         oam_start_q  <= ioreg_we && (ioreg_addr == dma_pkg::REG_OAM_DMA);
         gdma_start_q <= ioreg_we && (ioreg_addr == dma_pkg::REG_GDMA_CTRL)
                         && !ioreg_data[7];    // bit 7 set would be H-blank mode, not supported
      end
   end

   assign len_blocks = {1'b0, blocks_q} + 8'd1;   // 1..128 blocks

   assign cfg.oam_start    = oam_start_q;
   assign cfg.oam_src_page = oam_page_q;
   assign cfg.gdma_start   = gdma_start_q;

   assign cfg.gdma_src = {src_hi_q, src_lo_q & dma_pkg::ALIGN_MASK};

   // destination is always forced into 8000-9FF0
   assign cfg.gdma_dst = dma_pkg::VRAM_BASE
                         + {3'b000, dst_hi_q[4:0], 8'h00}
                         + {8'h00, dst_lo_q & dma_pkg::ALIGN_MASK};

   assign cfg.gdma_len = dma_pkg::xfer_len_t'(len_blocks * dma_pkg::GDMA_BLOCK);

endmodule

/* dma_engine/oam_dma_engine.sv */
`timescale 1ns/10ps

module oam_dma_engine (
   input  logic          I_CLK,
   input  logic          I_SYNC_RESET,
   dma_cfg_if.oam        cfg,
   dma_xfer_if.engine    xfer
);

   dma_pkg::oam_state_e   state_q;
   dma_pkg::byte_t        count_q;             // byte offset, 0..159
   dma_pkg::byte_t        page_q;              // source page, held for the whole copy
   logic                  start_ok;

   assign start_ok = (state_q == dma_pkg::OAM_IDLE) && cfg.oam_start;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         state_q <= dma_pkg::OAM_IDLE;
         count_q <= '0;
      end else begin
         case (state_q)
            dma_pkg::OAM_IDLE: begin
               if (cfg.oam_start) begin
                  state_q <= dma_pkg::OAM_COPY;
                  count_q <= '0;
               end
            end
            dma_pkg::OAM_COPY: begin
               if (xfer.grant) begin
                  if (count_q == dma_pkg::byte_t'(dma_pkg::OAM_LEN - 1)) begin
                     state_q <= dma_pkg::OAM_IDLE;   // last of the 160 bytes
                     count_q <= '0;
                  end else begin
                     count_q <= count_q + 8'd1;
                  end
               end
            end
            default: state_q <= dma_pkg::OAM_IDLE;
         endcase
      end
   end

   // a start while copying is dropped, so the page must not move
   always_ff @(posedge I_CLK) begin
      if (start_ok) begin
         page_q <= cfg.oam_src_page;
      end
   end

   assign xfer.active   = (state_q == dma_pkg::OAM_COPY);
   assign xfer.src_addr = {page_q, count_q};
   assign xfer.dst_addr = {dma_pkg::OAM_PAGE, count_q};

   a_oam_count_range: assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      count_q <= dma_pkg::byte_t'(dma_pkg::OAM_LEN - 1));

endmodule

/* dma_engine/gdma_engine.sv */
`timescale 1ns/10ps

module gdma_engine (
   input  logic          I_CLK,
   input  logic          I_SYNC_RESET,
   dma_cfg_if.gdma       cfg,
   dma_xfer_if.engine    xfer
);

   dma_pkg::gdma_state_e   state_q;
   dma_pkg::xfer_len_t     offset_q;          // bytes already moved
   dma_pkg::xfer_len_t     len_q;
   dma_pkg::addr_t         src_q;
   dma_pkg::addr_t         dst_q;
   logic                   start_ok;
   logic                   last_byte;

   assign start_ok  = (state_q == dma_pkg::GDMA_IDLE) && cfg.gdma_start;
   assign last_byte = (offset_q == len_q - 12'd1);

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         state_q  <= dma_pkg::GDMA_IDLE;
         offset_q <= '0;
      end else begin
         case (state_q)
            dma_pkg::GDMA_IDLE: begin
               if (cfg.gdma_start) begin
                  state_q  <= dma_pkg::GDMA_COPY;
                  offset_q <= '0;
               end
            end
            dma_pkg::GDMA_COPY: begin
               // no grant means OAM DMA owns the port, just hold position
               if (xfer.grant) begin
                  if (last_byte) begin
                     state_q  <= dma_pkg::GDMA_IDLE;
                     offset_q <= '0;
                  end else begin
                     offset_q <= offset_q + 12'd1;
                  end
               end
            end
            default: state_q <= dma_pkg::GDMA_IDLE;
         endcase
      end
   end

   // transfer parameters captured once per start
   always_ff @(posedge I_CLK) begin
      if (start_ok) begin
         src_q <= cfg.gdma_src;
         dst_q <= cfg.gdma_dst;
         len_q <= cfg.gdma_len;
      end
   end

   assign xfer.active   = (state_q == dma_pkg::GDMA_COPY);
   assign xfer.src_addr = src_q + dma_pkg::addr_t'(offset_q);
   assign xfer.dst_addr = dst_q + dma_pkg::addr_t'(offset_q);

   // offset must stay inside the block run that was started
   a_gdma_offset_range: assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      (state_q == dma_pkg::GDMA_COPY) |-> (offset_q < len_q));

endmodule

/* design/dma_bus_arbiter.sv */
`timescale 1ns/10ps

module dma_bus_arbiter (
   input  logic             I_CLK,
   input  logic             I_SYNC_RESET,
   dma_xfer_if.arbiter      oam,
   dma_xfer_if.arbiter      gdma,
   output dma_pkg::addr_t   rdma_addr,
   output logic             rdma_re_l,
   output dma_pkg::addr_t   wdma_addr,
   output logic             wdma_we_l,
   output logic             halt_cpu
);

   logic   any_grant;

   // OAM DMA always wins while general DMA waits it out
   assign oam.grant  = oam.active;
   assign gdma.grant = gdma.active && !oam.active;
   assign any_grant  = oam.grant || gdma.grant;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         rdma_re_l <= 1'b1;
         wdma_we_l <= 1'b1;
         halt_cpu  <= 1'b0;
      end else begin
         rdma_re_l <= !any_grant;              // read and write in the same cycle
         wdma_we_l <= !any_grant;
         halt_cpu  <= gdma.active;             // stays up while stalled behind OAM
      end
   end

   // port addresses only follow the winner
   always_ff @(posedge I_CLK) begin
      if (oam.grant) begin
         rdma_addr <= oam.src_addr;
         wdma_addr <= oam.dst_addr;
      end else if (gdma.grant) begin
         rdma_addr <= gdma.src_addr;
         wdma_addr <= gdma.dst_addr;
      end
   end

   a_one_grant: assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      !(oam.grant && gdma.grant));

   a_strobes_paired: assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      rdma_re_l == wdma_we_l);

endmodule

/* design/dma_controller.sv */
`timescale 1ns/10ps

module dma_controller (
   input  logic             I_CLK,
   input  logic             I_SYNC_RESET,
   // I/O register write bus
   input  dma_pkg::addr_t   ioreg_addr,
   input  dma_pkg::byte_t   ioreg_data,
   input  logic             ioreg_we,
   // memory read side
   output dma_pkg::addr_t   rdma_addr,
   input  dma_pkg::byte_t   rdma_data,
   output logic             rdma_re_l,
   // memory write side
   output dma_pkg::addr_t   wdma_addr,
   output dma_pkg::byte_t   wdma_data,
   output logic             wdma_we_l,
   output logic             halt_cpu
);

   dma_cfg_if    cfg_if ();
   dma_xfer_if   oam_xfer_if ();
   dma_xfer_if   gdma_xfer_if ();

   dma_reg_decode dma_reg_decode_inst (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .ioreg_addr   (ioreg_addr),
      .ioreg_data   (ioreg_data),
      .ioreg_we     (ioreg_we),
      .cfg          (cfg_if.decode)
   );

   oam_dma_engine oam_dma_engine_inst (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .cfg          (cfg_if.oam),
      .xfer         (oam_xfer_if.engine)
   );

   gdma_engine gdma_engine_inst (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .cfg          (cfg_if.gdma),
      .xfer         (gdma_xfer_if.engine)
   );

   dma_bus_arbiter dma_bus_arbiter_inst (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .oam          (oam_xfer_if.arbiter),
      .gdma         (gdma_xfer_if.arbiter),
      .rdma_addr    (rdma_addr),
      .rdma_re_l    (rdma_re_l),
      .wdma_addr    (wdma_addr),
      .wdma_we_l    (wdma_we_l),
      .halt_cpu     (halt_cpu)
   );

   assign wdma_data = rdma_data;               // zero latency memory, byte goes straight across

endmodule

/* test/tb_dma_controller.sv */
`timescale 1ns/10ps

module tb_dma_controller;

   localparam int NUM_TESTS   = 7;
   localparam int WORST_CYCLE = 2048 + 160 + 100;     // longest general DMA plus one OAM copy
   localparam int WATCHDOG_NS = (NUM_TESTS * WORST_CYCLE + 200) * 8;

   logic             I_CLK;
   logic             I_SYNC_RESET;
   dma_pkg::addr_t   ioreg_addr;
   dma_pkg::byte_t   ioreg_data;
   logic             ioreg_we;
   dma_pkg::addr_t   rdma_addr;
   dma_pkg::byte_t   rdma_data;
   logic             rdma_re_l;
   dma_pkg::addr_t   wdma_addr;
   dma_pkg::byte_t   wdma_data;
   logic             wdma_we_l;
   logic             halt_cpu;

   logic [31:0]      oam_q[$];                        // {read addr, write addr} still expected
   logic [31:0]      gdma_q[$];
   logic             in_oam;
   logic             in_gdma;
   int               cyc;
   int               last_write_edge;
   int               oam_due;                         // cycle of the next first access or 0 for none
   int               gdma_due;
   int               oam_seen;
   int               gdma_seen;
   int               writes_seen;
   int               err_count;
   int               test_errs;
   int               test_count;

   dma_controller dma_controller_inst (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .ioreg_addr   (ioreg_addr),
      .ioreg_data   (ioreg_data),
      .ioreg_we     (ioreg_we),
      .rdma_addr    (rdma_addr),
      .rdma_data    (rdma_data),
      .rdma_re_l    (rdma_re_l),
      .wdma_addr    (wdma_addr),
      .wdma_data    (wdma_data),
      .wdma_we_l    (wdma_we_l),
      .halt_cpu     (halt_cpu)
   );

   assign rdma_data = rdma_addr[7:0] ^ rdma_addr[15:8];   // memory content follows the address

   always #4 I_CLK = ~I_CLK;

   always @(posedge I_CLK) cyc <= cyc + 1;

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("CHECK FAILED at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, act);
      err_count++;
   endtask

   task automatic compare_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      assert (exp === act) else report_mismatch(name, exp, act);
   endtask

   task automatic note_failure(input string what);
      $display("ERROR at %0t: %s", $time, what);
      err_count++;
   endtask

   // sort one port cycle by where the byte is written
   task automatic check_cycle();
      logic          is_access;
      logic          is_oam;
      logic [31:0]   exp;
      is_access = !rdma_re_l;
      is_oam    = is_access && (wdma_addr[15:8] == dma_pkg::OAM_PAGE);
      if (!wdma_we_l)
         writes_seen++;
      if (is_access)
         compare_value("wdma_we_l", 1'b0, wdma_we_l);   // every read is also a write
      assert (!in_oam || is_oam) else note_failure("OAM transfer left the port early");
      if (is_oam) begin
         assert (oam_q.size() != 0) else note_failure("OAM access with none expected");
         if (oam_q.size() != 0) begin
            if (!in_oam && oam_due != 0)
               compare_value("first OAM access cycle", oam_due, cyc);
            exp = oam_q.pop_front();
            compare_value("rdma_addr", exp[31:16], rdma_addr);
            compare_value("wdma_addr", exp[15:0], wdma_addr);
            in_oam = (oam_q.size() != 0);
            oam_seen++;
         end
      end else if (is_access) begin
         assert (gdma_q.size() != 0) else note_failure("general DMA access with none expected");
         if (gdma_q.size() != 0) begin
            if (!in_gdma && gdma_due != 0)
               compare_value("first general DMA access cycle", gdma_due, cyc);
            in_gdma = 1'b1;
            exp = gdma_q.pop_front();
            compare_value("rdma_addr", exp[31:16], rdma_addr);
            compare_value("wdma_addr", exp[15:0], wdma_addr);
            gdma_seen++;
         end
      end
      compare_value("halt_cpu", in_gdma, halt_cpu);
      if (gdma_q.size() == 0)
         in_gdma = 1'b0;                              // halt must drop on the next cycle
   endtask

   always @(negedge I_CLK) begin
      if (!I_SYNC_RESET)
         check_cycle();
   end

   a_data_through: assert property (@(negedge I_CLK) disable iff (I_SYNC_RESET)
      !wdma_we_l |-> (wdma_data == rdma_data))
      else report_mismatch("wdma_data", rdma_data, wdma_data);

   a_reset_idle: assert property (@(posedge I_CLK)
      I_SYNC_RESET |=> (rdma_re_l && wdma_we_l && !halt_cpu))
      else note_failure("port strobes or halt_cpu not idle after reset");

   task automatic write_reg(input dma_pkg::addr_t addr, input dma_pkg::byte_t data);
      @(posedge I_CLK);
      #1;
      ioreg_addr      = addr;
      ioreg_data      = data;
      ioreg_we        = 1'b1;
      last_write_edge = cyc + 1;                      // edge that samples this write
      @(posedge I_CLK);
      #1;
      ioreg_we = 1'b0;
   endtask

   task automatic start_oam(input dma_pkg::byte_t page);
      int i;
      for (i = 0; i < dma_pkg::OAM_LEN; i++)
         oam_q.push_back({page, 8'(i), dma_pkg::OAM_PAGE, 8'(i)});
      write_reg(dma_pkg::REG_OAM_DMA, page);
      oam_due = last_write_edge + 2;
   endtask

   task automatic start_gdma(input logic [6:0] blocks);
      dma_pkg::byte_t   s_hi;
      dma_pkg::byte_t   s_lo;
      dma_pkg::byte_t   d_hi;
      dma_pkg::byte_t   d_lo;
      dma_pkg::addr_t   src;
      dma_pkg::addr_t   dst;
      int               i;
      s_hi = 8'($urandom);
      s_lo = 8'($urandom);
      d_hi = 8'($urandom);
      d_lo = 8'($urandom);
      write_reg(dma_pkg::REG_GDMA_SRC_HI, s_hi);
      write_reg(dma_pkg::REG_GDMA_SRC_LO, s_lo);
      write_reg(dma_pkg::REG_GDMA_DST_HI, d_hi);
      write_reg(dma_pkg::REG_GDMA_DST_LO, d_lo);
      src = {s_hi, s_lo[7:4], 4'h0};
      dst = {3'b100, d_hi[4:0], d_lo[7:4], 4'h0};     // VRAM at 8000-9FF0
      for (i = 0; i < 16 * (blocks + 1); i++)
         gdma_q.push_back({src + 16'(i), dst + 16'(i)});
      write_reg(dma_pkg::REG_GDMA_CTRL, {1'b0, blocks});
      gdma_due = last_write_edge + 2;
   endtask

   // let the queues drain and catch any extra access in a few quiet cycles
   task automatic wait_idle();
      int n;
      n = 0;
      while ((oam_q.size() != 0 || gdma_q.size() != 0) && n < WORST_CYCLE) begin
         @(posedge I_CLK);
         n++;
      end
      assert (n < WORST_CYCLE) else note_failure("transfer did not finish in time");
      repeat (8) @(posedge I_CLK);
   endtask

   task automatic begin_test();
      oam_seen    = 0;
      gdma_seen   = 0;
      writes_seen = 0;
      oam_due     = 0;
      gdma_due    = 0;
      test_errs   = err_count;
   endtask

   task automatic end_test(input string name, input int exp_oam, input int exp_gdma);
      compare_value("OAM access count", exp_oam, oam_seen);
      compare_value("general DMA access count", exp_gdma, gdma_seen);
      compare_value("write strobe count", exp_oam + exp_gdma, writes_seen);
      test_count++;
      $display("test %-22s %s (%0d errors)", name,
               (err_count == test_errs) ? "ok" : "FAILED", err_count - test_errs);
   endtask

   initial begin
      logic [6:0] blocks;
      void'($urandom(26692));
      I_CLK        = 1'b0;
      I_SYNC_RESET = 1'b1;
      ioreg_addr   = '0;
      ioreg_data   = '0;
      ioreg_we     = 1'b0;
      in_oam       = 1'b0;
      in_gdma      = 1'b0;
      cyc          = 0;
      writes_seen  = 0;
      err_count    = 0;
      test_count   = 0;
      repeat (2) @(posedge I_CLK);
      #1 I_SYNC_RESET = 1'b0;

      begin_test();
      repeat (20) @(posedge I_CLK);
      end_test("reset", 0, 0);

      begin_test();
      start_oam(8'($urandom));
      wait_idle();
      end_test("oam_dma", 160, 0);

      begin_test();
      blocks = 7'($urandom);
      start_gdma(blocks);
      wait_idle();
      end_test("general_dma", 0, 16 * (blocks + 1));

      begin_test();
      blocks = 7'(8 + ($urandom % 64));
      start_gdma(blocks);
      repeat (20) @(posedge I_CLK);
      start_oam(8'($urandom));                        // lands in the middle of the general DMA
      wait_idle();
      end_test("priority", 160, 16 * (blocks + 1));

      begin_test();
      write_reg(dma_pkg::REG_GDMA_CTRL, 8'h80 | 8'($urandom));
      repeat (40) @(posedge I_CLK);
      end_test("ignored_hblank_start", 0, 0);

      begin_test();
      start_oam(8'($urandom));
      repeat (50) @(posedge I_CLK);
      write_reg(dma_pkg::REG_OAM_DMA, 8'($urandom));
      wait_idle();
      end_test("ignored_oam_restart", 160, 0);

      begin_test();
      blocks = 7'(4 + ($urandom % 32));
      start_gdma(blocks);
      repeat (30) @(posedge I_CLK);
      write_reg(dma_pkg::REG_GDMA_CTRL, {1'b0, 7'($urandom)});
      wait_idle();
      end_test("ignored_gdma_restart", 0, 16 * (blocks + 1));

      $display("tests run: %0d, errors: %0d", test_count, err_count);
      if (err_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("ERROR: watchdog expired before all tests finished");
      $display("Regression failed");
      $finish;
   end

endmodule

/* build.f */
common/dma_pkg.sv
common/dma_cfg_if.sv
common/dma_xfer_if.sv
design/dma_reg_decode.sv
dma_engine/oam_dma_engine.sv
dma_engine/gdma_engine.sv
design/dma_bus_arbiter.sv
design/dma_controller.sv
test/tb_dma_controller.sv

/* Bender.yml */
package:
  name: dma_controller

sources:
  - files:
      - common/dma_pkg.sv
      - common/dma_cfg_if.sv
      - common/dma_xfer_if.sv
      - design/dma_reg_decode.sv
      - dma_engine/oam_dma_engine.sv
      - dma_engine/gdma_engine.sv
      - design/dma_bus_arbiter.sv
      - design/dma_controller.sv
  - target: test
    files:
      - test/tb_dma_controller.sv
